//--- filelist.f
common/n64v_pkg.sv
ppu/n64v_vdemux.sv
ppu/n64v_line_timer.sv
ppu/n64v_pixel_out.sv
ctrl/n64v_mode_detect.sv
hw/n64v_top.sv
verif/n64v_clk_gen.sv
verif/n64v_tb.sv

//--- verif/n64v_tb.sv
module n64v_tb;

  import n64v_pkg::*;

  localparam int LINE_PIXELS = 24;
  localparam int NUM_FIELDS  = 10;
  localparam int CLK_PERIOD  = 10;

  // Field sequence, NTSC then PAL with deblur, then alternating 13/12
  int   field_lines [NUM_FIELDS] = '{12, 12, 12, 16, 16, 16, 13, 12, 13, 12};
  logic field_blur  [NUM_FIELDS] = '{0, 0, 0, 1, 1, 1, 0, 0, 0, 0};

  logic      HDMI_CLK_w;
  logic      HDMI_nRST_w;
  logic      n_vdsync_i;
  n64_word_t vd_i;
  logic      deblur_en_i;
  logic      vid_vld_o;
  logic      vsync_o;
  logic      hsync_o;
  logic      de_o;
  rgb24_t    vd_o;
  logic      pal_o;
  logic      interlaced_o;
  logic      mode_vld_o;

  // Expected outputs, packed as {vsync, hsync, de, rgb}
  logic [26:0] exp_q [$];
  logic [31:0] lfsr_q = 32'h25769462;
  // Previous sent pixel, for the deblur predecessor
  logic        prev_act;
  logic [20:0] prev_rgb;

  n64v_clk_gen clk_gen_u (
    .HDMI_CLK_w  (HDMI_CLK_w),
    .HDMI_nRST_w (HDMI_nRST_w)
  );

  n64v_top DUT (
    .HDMI_CLK_w   (HDMI_CLK_w),
    .HDMI_nRST_w  (HDMI_nRST_w),
    .n_vdsync_i   (n_vdsync_i),
    .vd_i         (vd_i),
    .deblur_en_i  (deblur_en_i),
    .vid_vld_o    (vid_vld_o),
    .vsync_o      (vsync_o),
    .hsync_o      (hsync_o),
    .de_o         (de_o),
    .vd_o         (vd_o),
    .pal_o        (pal_o),
    .interlaced_o (interlaced_o),
    .mode_vld_o   (mode_vld_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, right shifting
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per colour bit
  function automatic n64_word_t rand_word();
    n64_word_t w;
    int        i;
    w = '0;
    for (i = 0; i < 7; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[5:0], lfsr_q[0]};
    end
    return w;
  endfunction

  // Expected video output for one sent pixel
  function automatic logic [26:0] ref_pixel(input logic [3:0] sync, input int px,
      input int ln, input logic blur, input logic has_prev, input logic [20:0] cur,
      input logic [20:0] prev);
    logic        active;
    logic [20:0] mix;
    logic [23:0] rgb;
    int          c;
    active = (px >= H_START) && (px < H_START + H_ACTIVE) &&
             (ln >= V_START) && (ln < V_START + V_ACTIVE);
    mix = cur;
    // Floor average with the previous active pixel
    if (blur && has_prev) begin
      for (c = 0; c < 3; c++) begin
        mix[c*7 +: 7] = ({1'b0, cur[c*7 +: 7]} + {1'b0, prev[c*7 +: 7]}) >> 1;
      end
    end
    // Top bit becomes the new LSB
    for (c = 0; c < 3; c++) begin
      rgb[c*8 +: 8] = {mix[c*7 +: 7], mix[c*7 + 6]};
    end
    if (!active) begin
      rgb = '0;
    end
    return {sync[SYNC_VS_BIT], sync[SYNC_HS_BIT], active, rgb};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
      input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] time %0t %s expected %0h actual %0h", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // One bus word, driven on the falling edge
  task automatic drive_word(input logic n_sync, input n64_word_t word);
    @(negedge HDMI_CLK_w);
    n_vdsync_i = n_sync;
    vd_i       = word;
  endtask

  // Stray sync and red first when asked, that group is then cut short
  task automatic send_group(input logic [3:0] sync, input logic [20:0] rgb,
      input logic stray);
    if (stray) begin
      drive_word(1'b0, {3'b000, sync});
      drive_word(1'b1, rand_word());
    end
    drive_word(1'b0, {3'b000, sync});
    drive_word(1'b1, rgb[20:14]);
    drive_word(1'b1, rgb[13:7]);
    drive_word(1'b1, rgb[6:0]);
  endtask

  // Mode seen after the vsync fall that opened field f
  task automatic check_mode(input int f);
    if (f == 0) begin
      check_value("mode_vld_o", 0, mode_vld_o);
    end else begin
      check_value("mode_vld_o", 1, mode_vld_o);
      check_value("pal_o", field_lines[f-1] >= PAL_LINES_MIN, pal_o);
      if (f >= 2) begin
        check_value("interlaced_o", field_lines[f-1] != field_lines[f-2], interlaced_o);
      end
    end
  endtask

  task automatic send_field(input int f);
    logic [3:0]  sync;
    logic [20:0] rgb;
    logic [26:0] want;
    int          ln;
    int          px;
    deblur_en_i = field_blur[f];
    for (ln = 0; ln < field_lines[f]; ln++) begin
      for (px = 0; px < LINE_PIXELS; px++) begin
        // hsync low for two pixels per line, vsync along with it on line 0
        sync = 4'b1111;
        sync[SYNC_HS_BIT] = (px >= 2);
        sync[SYNC_CS_BIT] = (px >= 2);
        sync[SYNC_VS_BIT] = !((ln == 0) && (px < 2));
        rgb[20:14] = rand_word();
        rgb[13:7]  = rand_word();
        rgb[6:0]   = rand_word();
        want = ref_pixel(sync, px, ln, field_blur[f], prev_act, rgb, prev_rgb);
        exp_q.push_back(want);
        prev_act = want[24];
        prev_rgb = rgb;
        send_group(sync, rgb, (ln % 2 == 1) && (px == 9));
      end
      if (ln == 0) begin
        check_mode(f);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Processes
  ////////////////////////////////////////////////////////////////////////////

  // Outputs settle after the rising edge, read them on the falling one
  always @(negedge HDMI_CLK_w) begin : compare_outputs
    logic [26:0] want;
    if (HDMI_nRST_w && vid_vld_o) begin
      if (exp_q.size() == 0) begin
        $display("Output pixel at time %0t with no pixel expected", $time);
        $display("SIMULATION FAILED");
        $fatal(1, "Unexpected output pixel");
      end else begin
        want = exp_q.pop_front();
        check_value("vsync_o", want[26], vsync_o);
        check_value("hsync_o", want[25], hsync_o);
        check_value("de_o", want[24], de_o);
        check_value("vd_o", want[23:0], vd_o);
      end
    end
  end

  // Four cycles per group, one stray group at most per line
  initial begin : watchdog
    int groups;
    int f;
    groups = 0;
    for (f = 0; f < NUM_FIELDS; f++) begin
      groups += field_lines[f] * (LINE_PIXELS + 1);
    end
    #((groups * 4 + 200) * CLK_PERIOD);
    $display("Run timed out before all pixels were checked");
    $display("SIMULATION FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin : stimulus
    int f;
    n_vdsync_i  = 1'b1;
    vd_i        = '0;
    deblur_en_i = 1'b0;
    prev_act    = 1'b0;
    prev_rgb    = '0;
    @(posedge HDMI_nRST_w);
    @(negedge HDMI_CLK_w);
    // Idle outputs, syncs inactive high
    check_value("vid_vld_o", 0, vid_vld_o);
    check_value("de_o", 0, de_o);
    check_value("mode_vld_o", 0, mode_vld_o);
    check_value("vsync_o", 1, vsync_o);
    check_value("hsync_o", 1, hsync_o);
    for (f = 0; f < NUM_FIELDS; f++) begin
      send_field(f);
    end
    // Drain the pipeline, late extra pixels still get caught
    while (exp_q.size() != 0) begin
      @(negedge HDMI_CLK_w);
    end
    repeat (8) @(negedge HDMI_CLK_w);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- verif/n64v_clk_gen.sv
module n64v_clk_gen (
  output logic HDMI_CLK_w,
  output logic HDMI_nRST_w
);

  // 10 unit period
  initial begin
    HDMI_CLK_w = 1'b0;
    forever #5 HDMI_CLK_w = ~HDMI_CLK_w;
  end

  // Reset held for 10 cycles, released away from the rising edge
  initial begin
    HDMI_nRST_w = 1'b0;
    repeat (10) @(posedge HDMI_CLK_w);
    @(negedge HDMI_CLK_w);
    HDMI_nRST_w = 1'b1;
  end

endmodule

//--- hw/n64v_top.sv
module n64v_top (
  input  logic                HDMI_CLK_w,
  input  logic                HDMI_nRST_w,
  input  logic                n_vdsync_i,
  input  n64v_pkg::n64_word_t vd_i,
  input  logic                deblur_en_i,
  output logic                vid_vld_o,
  output logic                vsync_o,
  output logic                hsync_o,
  output logic                de_o,
  output n64v_pkg::rgb24_t    vd_o,
  output logic                pal_o,
  output logic                interlaced_o,
  output logic                mode_vld_o
);

  import n64v_pkg::*;

  // Demuxed pixel
  logic      pix_vld;
  sync4_t    pix_sync;
  n64_word_t pix_r;
  n64_word_t pix_g;
  n64_word_t pix_b;
  logic      pix_active;

  ////////////////////////////////////////////////////////////////////////////
  // Bus demux
  ////////////////////////////////////////////////////////////////////////////

  n64v_vdemux vdemux_u (
    .HDMI_CLK_w  (HDMI_CLK_w),
    .HDMI_nRST_w (HDMI_nRST_w),
    .n_vdsync_i  (n_vdsync_i),
    .vd_i        (vd_i),
    .pix_vld_o   (pix_vld),
    .pix_sync_o  (pix_sync),
    .pix_r_o     (pix_r),
    .pix_g_o     (pix_g),
    .pix_b_o     (pix_b)
  );

  // Active window, same cycle as the strobe
  n64v_line_timer line_timer_u (
    .HDMI_CLK_w   (HDMI_CLK_w),
    .HDMI_nRST_w  (HDMI_nRST_w),
    .pix_vld_i    (pix_vld),
    .pix_sync_i   (pix_sync),
    .pix_active_o (pix_active)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Video out and mode
  ////////////////////////////////////////////////////////////////////////////

  n64v_pixel_out pixel_out_u (
    .HDMI_CLK_w   (HDMI_CLK_w),
    .HDMI_nRST_w  (HDMI_nRST_w),
    .deblur_en_i  (deblur_en_i),
    .pix_vld_i    (pix_vld),
    .pix_sync_i   (pix_sync),
    .pix_r_i      (pix_r),
    .pix_g_i      (pix_g),
    .pix_b_i      (pix_b),
    .pix_active_i (pix_active),
    .vid_vld_o    (vid_vld_o),
    .vsync_o      (vsync_o),
    .hsync_o      (hsync_o),
    .de_o         (de_o),
    .vd_o         (vd_o)
  );

  n64v_mode_detect mode_detect_u (
    .HDMI_CLK_w   (HDMI_CLK_w),
    .HDMI_nRST_w  (HDMI_nRST_w),
    .pix_vld_i    (pix_vld),
    .pix_sync_i   (pix_sync),
    .pal_o        (pal_o),
    .interlaced_o (interlaced_o),
    .mode_vld_o   (mode_vld_o)
  );

endmodule

//--- ctrl/n64v_mode_detect.sv
module n64v_mode_detect (
  input  logic             HDMI_CLK_w,
  input  logic             HDMI_nRST_w,
  input  logic             pix_vld_i,
  input  n64v_pkg::sync4_t pix_sync_i,
  output logic             pal_o,
  output logic             interlaced_o,
  output logic             mode_vld_o
);

  import n64v_pkg::*;

  // Previous sync bits seen on a strobe
  logic hs_q;
  logic vs_q;

  // Lines of the running field and of the last finished one
  cnt_t line_cnt_q;
  cnt_t prev_cnt_q;

  // First vsync fall seen
  logic vs_seen_q;

  logic hs_fall;
  logic vs_fall;

  assign hs_fall = pix_vld_i && hs_q && !pix_sync_i[SYNC_HS_BIT];
  assign vs_fall = pix_vld_i && vs_q && !pix_sync_i[SYNC_VS_BIT];

  ////////////////////////////////////////////////////////////////////////////
  // Edge tracking and line count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      hs_q       <= 1'b1;
      vs_q       <= 1'b1;
      line_cnt_q <= '0;
    end else if (pix_vld_i) begin
      hs_q <= pix_sync_i[SYNC_HS_BIT];
      vs_q <= pix_sync_i[SYNC_VS_BIT];
      // New field starts empty
      if (vs_fall) begin
        line_cnt_q <= '0;
      end else if (hs_fall && (line_cnt_q != '1)) begin
        line_cnt_q <= line_cnt_q + cnt_t'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Field classification
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      prev_cnt_q   <= '0;
      vs_seen_q    <= 1'b0;
      pal_o        <= 1'b0;
      interlaced_o <= 1'b0;
      mode_vld_o   <= 1'b0;
    end else if (vs_fall) begin
      prev_cnt_q   <= line_cnt_q;
      vs_seen_q    <= 1'b1;
      pal_o        <= (line_cnt_q >= PAL_LINES_MIN);
      // Odd and even fields differ by one line
      interlaced_o <= (line_cnt_q != prev_cnt_q);
      // Needs one complete field behind it
      if (vs_seen_q) begin
        mode_vld_o <= 1'b1;
      end
    end
  end

endmodule

//--- ppu/n64v_pixel_out.sv
module n64v_pixel_out (
  input  logic                HDMI_CLK_w,
  input  logic                HDMI_nRST_w,
  input  logic                deblur_en_i,
  input  logic                pix_vld_i,
  input  n64v_pkg::sync4_t    pix_sync_i,
  input  n64v_pkg::n64_word_t pix_r_i,
  input  n64v_pkg::n64_word_t pix_g_i,
  input  n64v_pkg::n64_word_t pix_b_i,
  input  logic                pix_active_i,
  output logic                vid_vld_o,
  output logic                vsync_o,
  output logic                hsync_o,
  output logic                de_o,
  output n64v_pkg::rgb24_t    vd_o
);

  import n64v_pkg::*;

  // Previous active pixel of this line
  logic      prev_vld_q;
  n64_word_t prev_r_q;
  n64_word_t prev_g_q;
  n64_word_t prev_b_q;

  logic   blend;
  rgb24_t pix_rgb;

  // Floor average of two channels
  function automatic n64_word_t avg7(input n64_word_t a, input n64_word_t b);
    logic [7:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[7:1];
  endfunction

  // 7 to 8 bit, top bit repeated as new LSB
  function automatic logic [7:0] widen(input n64_word_t c);
    return {c, c[6]};
  endfunction

  assign blend = deblur_en_i && prev_vld_q;

  always_comb begin
    if (blend) begin
      pix_rgb = {widen(avg7(pix_r_i, prev_r_q)),
                 widen(avg7(pix_g_i, prev_g_q)),
                 widen(avg7(pix_b_i, prev_b_q))};
    end else begin
      pix_rgb = {widen(pix_r_i), widen(pix_g_i), widen(pix_b_i)};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      vid_vld_o  <= 1'b0;
      // Syncs idle high
      vsync_o    <= 1'b1;
      hsync_o    <= 1'b1;
      de_o       <= 1'b0;
      vd_o       <= '0;
      prev_vld_q <= 1'b0;
    end else begin
      vid_vld_o <= pix_vld_i;
      if (pix_vld_i) begin
        vsync_o    <= pix_sync_i[SYNC_VS_BIT];
        hsync_o    <= pix_sync_i[SYNC_HS_BIT];
        de_o       <= pix_active_i;
        // Blank colour outside the window
        vd_o       <= pix_active_i ? pix_rgb : '0;
        prev_vld_q <= pix_active_i;
      end
    end
  end

  // Raw input kept, blending never chains
  always_ff @(posedge HDMI_CLK_w) begin
    if (pix_vld_i && pix_active_i) begin
      prev_r_q <= pix_r_i;
      prev_g_q <= pix_g_i;
      prev_b_q <= pix_b_i;
    end
  end

  // Output strobe lasts a single cycle
  assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    vid_vld_o |=> !vid_vld_o)
    else $error("vid_vld_o high on two consecutive cycles");

endmodule

//--- ppu/n64v_line_timer.sv
module n64v_line_timer (
  input  logic             HDMI_CLK_w,
  input  logic             HDMI_nRST_w,
  input  logic             pix_vld_i,
  input  n64v_pkg::sync4_t pix_sync_i,
  output logic             pix_active_o
);

  import n64v_pkg::*;

  // Sync bits of the previous strobe
  logic hs_q;
  logic vs_q;

  // Index of the next strobe on the line, and current line index
  cnt_t pix_q;
  cnt_t line_q;

  // Decode for the strobe in this cycle
  logic hs_fall;
  logic vs_fall;
  cnt_t pix_idx;
  cnt_t line_idx;
  logic h_in;
  logic v_in;

  // Active low sync, so a fall is high then low
  assign hs_fall = hs_q && !pix_sync_i[SYNC_HS_BIT];
  assign vs_fall = vs_q && !pix_sync_i[SYNC_VS_BIT];

  // Strobe carrying the edge is index 0
  assign pix_idx = hs_fall ? '0 : pix_q;

  // vsync wins over a coinciding hsync
  always_comb begin
    if (vs_fall) begin
      line_idx = '0;
    end else if (hs_fall && (line_q != '1)) begin
      line_idx = line_q + cnt_t'(1);
    end else begin
      line_idx = line_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Window decode
  ////////////////////////////////////////////////////////////////////////////

  assign h_in = (pix_idx >= H_START) && (pix_idx < H_START + H_ACTIVE);
  assign v_in = (line_idx >= V_START) && (line_idx < V_START + V_ACTIVE);

  assign pix_active_o = pix_vld_i && h_in && v_in;

  ////////////////////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      hs_q   <= 1'b1;
      vs_q   <= 1'b1;
      // All ones means not yet locked to an edge
      pix_q  <= '1;
      line_q <= '1;
    end else if (pix_vld_i) begin
      hs_q   <= pix_sync_i[SYNC_HS_BIT];
      vs_q   <= pix_sync_i[SYNC_VS_BIT];
      line_q <= line_idx;
      // Saturate so a missing hsync never wraps into the window
      if (pix_idx != '1) begin
        pix_q <= pix_idx + cnt_t'(1);
      end else begin
        pix_q <= pix_idx;
      end
    end
  end

  // Sync pulses end before the window opens
  assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    pix_active_o |-> (pix_sync_i[SYNC_HS_BIT] && pix_sync_i[SYNC_VS_BIT]))
    else $error("Active pixel inside a sync pulse");

endmodule

//--- ppu/n64v_vdemux.sv
module n64v_vdemux (
  input  logic                HDMI_CLK_w,
  input  logic                HDMI_nRST_w,
  input  logic                n_vdsync_i,
  input  n64v_pkg::n64_word_t vd_i,
  output logic                pix_vld_o,
  output n64v_pkg::sync4_t    pix_sync_o,
  output n64v_pkg::n64_word_t pix_r_o,
  output n64v_pkg::n64_word_t pix_g_o,
  output n64v_pkg::n64_word_t pix_b_o
);

  import n64v_pkg::*;

  // Input register stage
  logic      n_vdsync_q;
  n64_word_t vd_q;

  // Group assembly
  vdemux_state_t state_q;
  sync4_t        sync_hold_q;
  n64_word_t     red_hold_q;
  n64_word_t     green_hold_q;
  logic          emit;

  // Blue word sitting in the input register completes the group
  assign emit = n_vdsync_q && (state_q == ST_BLUE);

  ////////////////////////////////////////////////////////////////////////////
  // Control path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      // Idle bus level, no sync pending
      n_vdsync_q <= 1'b1;
      state_q    <= ST_SYNC;
      pix_vld_o  <= 1'b0;
    end else begin
      n_vdsync_q <= n_vdsync_i;
      pix_vld_o  <= emit;
      if (!n_vdsync_q) begin
        // Sync word restarts the group from any state
        state_q <= ST_RED;
      end else begin
        case (state_q)
          ST_RED:   state_q <= ST_GREEN;
          ST_GREEN: state_q <= ST_BLUE;
          ST_BLUE:  state_q <= ST_SYNC;
          // Wait here for the next sync word
          default:  state_q <= ST_SYNC;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HDMI_CLK_w) begin
    vd_q <= vd_i;
    // Sync bits live in the low nibble
    if (!n_vdsync_q) begin
      sync_hold_q <= vd_q[3:0];
    end
    if (n_vdsync_q && (state_q == ST_RED)) begin
      red_hold_q <= vd_q;
    end
    if (n_vdsync_q && (state_q == ST_GREEN)) begin
      green_hold_q <= vd_q;
    end
    // All four words leave together with the strobe
    if (emit) begin
      pix_sync_o <= sync_hold_q;
      pix_r_o    <= red_hold_q;
      pix_g_o    <= green_hold_q;
      pix_b_o    <= vd_q;
    end
  end

  // nVDSYNC marks one word per group, never two in a row
  assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    !n_vdsync_q |=> n_vdsync_q)
    else $error("nVDSYNC low on two consecutive samples");

endmodule

//--- common/n64v_pkg.sv
package n64v_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and pixel types
  ////////////////////////////////////////////////////////////////////////////

  // One word of the N64 video bus, also one colour channel
  typedef logic [6:0] n64_word_t;

  // Output pixel, red in the top byte
  typedef logic [23:0] rgb24_t;

  // Low nibble of the sync word, all bits active low
  typedef logic [3:0] sync4_t;

  // Pixel and line counts
  typedef logic [9:0] cnt_t;

  // Bit positions inside sync4_t
  localparam int SYNC_VS_BIT    = 3;
  localparam int SYNC_CLAMP_BIT = 2;
  localparam int SYNC_HS_BIT    = 1;
  localparam int SYNC_CS_BIT    = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Raster window, scaled down for short simulation
  ////////////////////////////////////////////////////////////////////////////

  // First active pixel after hsync fall, and active pixels per line
  localparam cnt_t H_START  = 10'd4;
  localparam cnt_t H_ACTIVE = 10'd16;

  // First active line after vsync fall, and active lines per field
  localparam cnt_t V_START  = 10'd2;
  localparam cnt_t V_ACTIVE = 10'd6;

  // Field line count from which the source counts as PAL
  localparam cnt_t PAL_LINES_MIN = 10'd14;

  // Demux FSM, state names the word expected next
  typedef enum logic [1:0] {
    ST_SYNC  = 2'd0,
    ST_RED   = 2'd1,
    ST_GREEN = 2'd2,
    ST_BLUE  = 2'd3
  } vdemux_state_t;

endpackage
